//--- common/rv32i_isa_pkg.sv
package rv32i_isa_pkg;

    // base opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    // alu funct3
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR  = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // branch and memory funct3
    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;
    localparam logic [2:0] F3_BLT    = 3'b100;
    localparam logic [2:0] F3_BGE    = 3'b101;
    localparam logic [2:0] F3_LW_SW  = 3'b010;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen through every format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage

//--- common/rv32i_pipe_pkg.sv
package rv32i_pipe_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_t;

    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_t;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_write;
        logic    mem_read;
        logic    branch;
        logic    jump;
        logic    jalr;
        logic    alu_src_imm;
        logic    pc_src_a;
        alu_t    alu;
        wb_sel_t wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [2:0]      funct3;
    } id_exe_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] target;
        logic            taken;
    } exe_mem_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [4:0]      rd;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] load_data;
    } mem_wb_t;

endpackage

//--- control_unit/control_unit.sv
module control_unit import rv32i_pipe_pkg::*, rv32i_isa_pkg::*; (
    input  inst_u      inst_id,
    input  logic [4:0] rs1_exe,
    input  logic [4:0] rs2_exe,
    input  logic [4:0] rd_exe,
    input  logic [4:0] rd_mem,
    input  logic [4:0] rd_wb,
    input  logic       mem_read_exe,
    input  logic       reg_write_mem,
    input  logic       reg_write_wb,
    input  logic       pc_sel_mem,
    input  logic       stall_pipl,
    output ctrl_t      ctrl_id,
    output fwd_t       forward_a_exe,
    output fwd_t       forward_b_exe,
    output logic       forward_a_id,
    output logic       forward_b_id,
    output logic       if_id_clr,
    output logic       id_exe_clr,
    output logic       exe_mem_clr,
    output logic       pc_en,
    output logic       if_id_en,
    output logic       id_exe_en,
    output logic       exe_mem_en,
    output logic       mem_wb_en,
    output logic       if_id_reg_en
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic [4:0] rs1_id, rs2_id;
    logic       uses_rs1, uses_rs2, load_use;

    assign opcode = inst_id.r_fmt.opcode;
    assign funct3 = inst_id.r_fmt.funct3;
    assign alt    = inst_id.r_fmt.funct7[5];
    assign rs1_id = inst_id.r_fmt.rs1;
    assign rs2_id = inst_id.r_fmt.rs2;

    function automatic alu_t alu_decode(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            F3_ADD:  return sub_sra ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return sub_sra ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // prefer the younger result sitting in memory over writeback
    function automatic fwd_t fwd_select(input logic [4:0] rs);
        if (reg_write_mem && rd_mem != '0 && rd_mem == rs) return FWD_MEM;
        if (reg_write_wb && rd_wb != '0 && rd_wb == rs) return FWD_WB;
        return FWD_NONE;
    endfunction

    always_comb begin
        ctrl_id = '0;
        case (opcode)
            OP_R: begin
                ctrl_id.reg_write = 1'b1;
                ctrl_id.alu       = alu_decode(funct3, alt);
            end
            OP_I: begin
                ctrl_id.reg_write   = 1'b1;
                ctrl_id.alu_src_imm = 1'b1;
                // addi has no subtract form, imm[10] only matters for shifts
                ctrl_id.alu         = alu_decode(funct3, funct3 == F3_SR && alt);
            end
            OP_LOAD: if (funct3 == F3_LW_SW) begin
                ctrl_id.reg_write   = 1'b1;
                ctrl_id.mem_read    = 1'b1;
                ctrl_id.alu_src_imm = 1'b1;
                ctrl_id.wb_sel      = WB_MEM;
            end
            OP_STORE: if (funct3 == F3_LW_SW) begin
                ctrl_id.mem_write   = 1'b1;
                ctrl_id.alu_src_imm = 1'b1;
            end
            OP_BRANCH: ctrl_id.branch = 1'b1;
            OP_JAL, OP_JALR: begin
                ctrl_id.reg_write   = 1'b1;
                ctrl_id.jump        = 1'b1;
                ctrl_id.jalr        = (opcode == OP_JALR);
                ctrl_id.alu_src_imm = 1'b1;
                ctrl_id.wb_sel      = WB_PC4;
            end
            OP_LUI: begin
                ctrl_id.reg_write   = 1'b1;
                ctrl_id.alu_src_imm = 1'b1;
                ctrl_id.alu         = ALU_PASS_B;
            end
            OP_AUIPC: begin
                ctrl_id.reg_write   = 1'b1;
                ctrl_id.pc_src_a    = 1'b1;
                ctrl_id.alu_src_imm = 1'b1;
            end
            default: ctrl_id = '0;
        endcase
    end

    always_comb begin
        forward_a_exe = fwd_select(rs1_exe);
        forward_b_exe = fwd_select(rs2_exe);
    end

    assign forward_a_id = reg_write_wb && rd_wb != '0 && rd_wb == rs1_id;
    assign forward_b_id = reg_write_wb && rd_wb != '0 && rd_wb == rs2_id;

    // u and j formats carry no source registers
    assign uses_rs1 = !(opcode inside {OP_LUI, OP_AUIPC, OP_JAL});
    assign uses_rs2 = opcode inside {OP_R, OP_STORE, OP_BRANCH};
    assign load_use = mem_read_exe && rd_exe != '0 &&
                      ((uses_rs1 && rs1_id == rd_exe) || (uses_rs2 && rs2_id == rd_exe));

    always_comb begin
        pc_en       = 1'b0;
        if_id_en    = 1'b0;
        id_exe_en   = 1'b0;
        exe_mem_en  = 1'b0;
        mem_wb_en   = 1'b0;
        if_id_clr   = 1'b0;
        id_exe_clr  = 1'b0;
        exe_mem_clr = 1'b0;
        if (!stall_pipl) begin
            // a redirect flushes the load-use pair anyway
            pc_en       = !load_use || pc_sel_mem;
            if_id_en    = !load_use || pc_sel_mem;
            id_exe_en   = 1'b1;
            exe_mem_en  = 1'b1;
            mem_wb_en   = 1'b1;
            if_id_clr   = pc_sel_mem;
            id_exe_clr  = pc_sel_mem || load_use;
            exe_mem_clr = pc_sel_mem;
        end
    end

    assign if_id_reg_en = if_id_en;

endmodule

//--- data_path/alu.sv
module alu import rv32i_pipe_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_t            op,
    input  logic [2:0]      funct3,
    output logic [XLEN-1:0] result,
    output logic            branch_taken
);

    logic equal;
    logic less;
    logic cond;

    assign equal = (a == b);
    assign less  = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, less};
            ALU_SLL:    result = a << b[4:0];
            ALU_SRL:    result = a >> b[4:0];
            ALU_SRA:    result = $signed(a) >>> b[4:0];
            default:    result = b;
        endcase
    end

    // funct3[2] picks less-than over equal, funct3[0] negates
    // unsigned compares (funct3[1] set) are not supported
    assign cond         = funct3[2] ? less : equal;
    assign branch_taken = !funct3[1] && (cond ^ funct3[0]);

endmodule

//--- data_path/data_path.sv
module data_path import rv32i_pipe_pkg::*, rv32i_isa_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [XLEN-1:0] inst,
    input  logic [XLEN-1:0] mem_rdata_mem,
    input  ctrl_t           ctrl_id,
    input  fwd_t            forward_a_exe,
    input  fwd_t            forward_b_exe,
    input  logic            forward_a_id,
    input  logic            forward_b_id,
    input  logic            if_id_clr,
    input  logic            id_exe_clr,
    input  logic            exe_mem_clr,
    input  logic            pc_en,
    input  logic            if_id_en,
    input  logic            id_exe_en,
    input  logic            exe_mem_en,
    input  logic            mem_wb_en,
    output logic [XLEN-1:0] current_pc,
    output logic [XLEN-1:0] mem_addr_mem,
    output logic [XLEN-1:0] mem_wdata_mem,
    output logic            mem_write_mem,
    output logic            mem_read_mem,
    output logic [2:0]      mem_op_mem,
    output inst_u           inst_id,
    output logic [4:0]      rs1_exe,
    output logic [4:0]      rs2_exe,
    output logic [4:0]      rd_exe,
    output logic [4:0]      rd_mem,
    output logic [4:0]      rd_wb,
    output logic            mem_read_exe,
    output logic            reg_write_mem,
    output logic            reg_write_wb,
    output logic            pc_sel_mem
);

    if_id_t   if_id_q;
    id_exe_t  id_exe_q;
    exe_mem_t exe_mem_q;
    mem_wb_t  mem_wb_q;

    logic [XLEN-1:0] imm_id, rdata1, rdata2, rs1_data_id, rs2_data_id;
    logic [XLEN-1:0] fwd_a, fwd_b, alu_a, alu_b, alu_result, target_exe;
    logic [XLEN-1:0] mem_fwd, wb_value;
    logic            branch_taken;

    // fetch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            current_pc <= RESET_PC;
        end else if (pc_en) begin
            current_pc <= pc_sel_mem ? exe_mem_q.target : current_pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id_q <= '{pc: RESET_PC, inst: NOP_INST};
        end else if (if_id_clr) begin
            if_id_q <= '{pc: RESET_PC, inst: NOP_INST};
        end else if (if_id_en) begin
            if_id_q <= '{pc: current_pc, inst: inst};
        end
    end

    // decode
    assign inst_id = if_id_q.inst;

    always_comb begin
        case (inst_id.r_fmt.opcode)
            OP_STORE:
                imm_id = {{20{inst_id.s_fmt.imm_hi[6]}}, inst_id.s_fmt.imm_hi,
                          inst_id.s_fmt.imm_lo};
            OP_BRANCH:
                imm_id = {{20{inst_id.b_fmt.imm_12}}, inst_id.b_fmt.imm_11,
                          inst_id.b_fmt.imm_10_5, inst_id.b_fmt.imm_4_1, 1'b0};
            OP_LUI, OP_AUIPC:
                imm_id = {inst_id.u_fmt.imm, 12'b0};
            OP_JAL:
                imm_id = {{12{inst_id.j_fmt.imm_20}}, inst_id.j_fmt.imm_19_12,
                          inst_id.j_fmt.imm_11, inst_id.j_fmt.imm_10_1, 1'b0};
            default:
                imm_id = {{20{inst_id.i_fmt.imm[11]}}, inst_id.i_fmt.imm};
        endcase
    end

    reg_file reg_file_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (inst_id.r_fmt.rs1),
        .rs2    (inst_id.r_fmt.rs2),
        .rd     (mem_wb_q.rd),
        .we     (mem_wb_q.ctrl.reg_write),
        .wdata  (wb_value),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // register file writes at the end of this cycle, so bypass the value now
    assign rs1_data_id = forward_a_id ? wb_value : rdata1;
    assign rs2_data_id = forward_b_id ? wb_value : rdata2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_exe_q <= '0;
        end else if (id_exe_clr) begin
            id_exe_q <= '0;
        end else if (id_exe_en) begin
            id_exe_q <= '{ctrl: ctrl_id, pc: if_id_q.pc, rs1: inst_id.r_fmt.rs1,
                          rs2: inst_id.r_fmt.rs2, rd: inst_id.r_fmt.rd,
                          rs1_data: rs1_data_id, rs2_data: rs2_data_id,
                          imm: imm_id, funct3: inst_id.r_fmt.funct3};
        end
    end

    // execute
    always_comb begin
        case (forward_a_exe)
            FWD_MEM: fwd_a = mem_fwd;
            FWD_WB:  fwd_a = wb_value;
            default: fwd_a = id_exe_q.rs1_data;
        endcase
        case (forward_b_exe)
            FWD_MEM: fwd_b = mem_fwd;
            FWD_WB:  fwd_b = wb_value;
            default: fwd_b = id_exe_q.rs2_data;
        endcase
    end

    assign alu_a = id_exe_q.ctrl.pc_src_a ? id_exe_q.pc : fwd_a;
    assign alu_b = id_exe_q.ctrl.alu_src_imm ? id_exe_q.imm : fwd_b;

    alu alu_inst (
        .a            (alu_a),
        .b            (alu_b),
        .op           (id_exe_q.ctrl.alu),
        .funct3       (id_exe_q.funct3),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    // jalr target comes out of the alu as rs1 + imm
    assign target_exe = id_exe_q.ctrl.jalr ? {alu_result[XLEN-1:1], 1'b0}
                                           : id_exe_q.pc + id_exe_q.imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_mem_q <= '0;
        end else if (exe_mem_clr) begin
            exe_mem_q <= '0;
        end else if (exe_mem_en) begin
            exe_mem_q <= '{ctrl: id_exe_q.ctrl, rd: id_exe_q.rd, funct3: id_exe_q.funct3,
                           alu_result: alu_result, store_data: fwd_b,
                           pc4: id_exe_q.pc + 32'd4, target: target_exe,
                           taken: branch_taken};
        end
    end

    // memory
    assign mem_addr_mem  = exe_mem_q.alu_result;
    assign mem_wdata_mem = exe_mem_q.store_data;
    assign mem_write_mem = exe_mem_q.ctrl.mem_write;
    assign mem_read_mem  = exe_mem_q.ctrl.mem_read;
    assign mem_op_mem    = exe_mem_q.funct3;
    assign pc_sel_mem    = exe_mem_q.ctrl.jump || (exe_mem_q.ctrl.branch && exe_mem_q.taken);
    // loads never forward from here since the load-use bubble covers them
    assign mem_fwd = (exe_mem_q.ctrl.wb_sel == WB_PC4) ? exe_mem_q.pc4 : exe_mem_q.alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb_q <= '0;
        end else if (mem_wb_en) begin
            mem_wb_q <= '{ctrl: exe_mem_q.ctrl, rd: exe_mem_q.rd,
                          alu_result: exe_mem_q.alu_result, pc4: exe_mem_q.pc4,
                          load_data: mem_rdata_mem};
        end
    end

    // writeback
    always_comb begin
        case (mem_wb_q.ctrl.wb_sel)
            WB_MEM:  wb_value = mem_wb_q.load_data;
            WB_PC4:  wb_value = mem_wb_q.pc4;
            default: wb_value = mem_wb_q.alu_result;
        endcase
    end

    // hazard info for the control unit
    assign rs1_exe       = id_exe_q.rs1;
    assign rs2_exe       = id_exe_q.rs2;
    assign rd_exe        = id_exe_q.rd;
    assign rd_mem        = exe_mem_q.rd;
    assign rd_wb         = mem_wb_q.rd;
    assign mem_read_exe  = id_exe_q.ctrl.mem_read;
    assign reg_write_mem = exe_mem_q.ctrl.reg_write;
    assign reg_write_wb  = mem_wb_q.ctrl.reg_write;

endmodule

//--- data_path/reg_file.sv
module reg_file import rv32i_pipe_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            we,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 is never written, so it always reads back zero
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

//--- source/rv32i.sv
module rv32i import rv32i_pipe_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            stall_pipl,

    // instruction fetch
    output logic [XLEN-1:0] current_pc,
    input  logic [XLEN-1:0] inst,

    // data memory bus
    output logic [XLEN-1:0] mem_addr_mem,
    output logic [XLEN-1:0] mem_wdata_mem,
    output logic            mem_write_mem,
    output logic            mem_read_mem,
    output logic [2:0]      mem_op_mem,
    input  logic [XLEN-1:0] mem_rdata_mem,

    output logic            if_id_reg_en
);

    // control unit to data path
    ctrl_t ctrl_id;
    fwd_t  forward_a_exe, forward_b_exe;
    logic  forward_a_id, forward_b_id;
    logic  if_id_clr, id_exe_clr, exe_mem_clr;
    logic  pc_en, if_id_en, id_exe_en, exe_mem_en, mem_wb_en;

    // data path to control unit
    logic [XLEN-1:0] inst_id;
    logic [4:0]      rs1_exe, rs2_exe, rd_exe, rd_mem, rd_wb;
    logic            mem_read_exe, reg_write_mem, reg_write_wb, pc_sel_mem;

    data_path data_path_inst (
        .*,
        .inst_id (inst_id)
    );

    control_unit controller_inst (
        .*,
        .inst_id (inst_id)
    );

endmodule

//--- verif/rv32i_tb.sv
module rv32i_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_TESTS      = 9;
    localparam int          NUM_PROGS      = 5;
    localparam int          PROG_WORDS     = 12;
    localparam int          RESET_CYCLES   = 10;
    localparam int          TIMEOUT_CYCLES = NUM_TESTS * (PROG_WORDS + 10) * 4;
    localparam int          SEED           = 65;
    localparam logic [31:0] RESULT_ADDR    = 32'h0000_0100;
    localparam int          RESULT_WORD    = RESULT_ADDR >> 2;
    localparam logic [31:0] RESET_PC_EXP   = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD       = 32'h0000_0013;
    // funct3 of lw and sw
    localparam logic [2:0]  F3_WORD        = 3'b010;

    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    logic        clk;
    logic        arst_n;
    logic        stall_pipl;
    logic [31:0] inst;
    logic [31:0] mem_rdata_mem;
    logic [31:0] current_pc;
    logic [31:0] mem_addr_mem;
    logic [31:0] mem_wdata_mem;
    logic        mem_write_mem;
    logic        mem_read_mem;
    logic [2:0]  mem_op_mem;
    logic        if_id_reg_en;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] programs [NUM_PROGS][PROG_WORDS];
    int unsigned cycle_count = 0;

    // test table where programs 0 to 3 run a second time under random back-pressure
    string       test_name  [NUM_TESTS] = '{"alu_fwd", "load_use", "branch", "jump",
                                            "lui_auipc", "alu_fwd_stall", "load_use_stall",
                                            "branch_stall", "jump_stall"};
    int          test_prog  [NUM_TESTS] = '{0, 1, 2, 3, 4, 0, 1, 2, 3};
    bit          test_stall [NUM_TESTS] = '{0, 0, 0, 0, 0, 1, 1, 1, 1};
    logic [31:0] test_exp   [NUM_TESTS] = '{32'h0000_0174, 32'h0000_0053, 32'h0000_000d,
                                            32'h0000_0024, 32'hedcb_9004, 32'h0000_0174,
                                            32'h0000_0053, 32'h0000_000d, 32'h0000_0024};

    rv32i i_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall_pipl    (stall_pipl),
        .current_pc    (current_pc),
        .inst          (inst),
        .mem_addr_mem  (mem_addr_mem),
        .mem_wdata_mem (mem_wdata_mem),
        .mem_write_mem (mem_write_mem),
        .mem_read_mem  (mem_read_mem),
        .mem_op_mem    (mem_op_mem),
        .mem_rdata_mem (mem_rdata_mem),
        .if_id_reg_en  (if_id_reg_en)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // both memories answer in the same cycle
    // data comes back only while the read strobe is up
    assign inst          = imem[current_pc[7:2]];
    assign mem_rdata_mem = mem_read_mem ? dmem[mem_addr_mem[9:2]] : '0;

    always @(posedge clk) begin
        if (mem_write_mem) begin
            dmem[mem_addr_mem[9:2]] <= mem_wdata_mem;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    // instruction encoders
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic build_programs();
        for (int p = 0; p < NUM_PROGS; p++) begin
            for (int i = 0; i < PROG_WORDS; i++) begin
                programs[p][i] = NOP_WORD;
            end
        end
        // dependent chain ending in x10 = 385 + (-13)
        programs[0][0]  = i_word(OPC_IMM, 3'b000, 1, 0, 5);
        programs[0][1]  = i_word(OPC_IMM, 3'b000, 2, 1, 7);
        programs[0][2]  = r_word(7'h00, 3'b000, 3, 1, 2);
        programs[0][3]  = r_word(7'h20, 3'b000, 4, 3, 1);
        programs[0][4]  = r_word(7'h00, 3'b001, 5, 4, 1);
        programs[0][5]  = i_word(OPC_IMM, 3'b100, 6, 5, -1);
        programs[0][6]  = r_word(7'h20, 3'b101, 7, 6, 1);
        programs[0][7]  = i_word(OPC_IMM, 3'b010, 8, 7, 0);
        programs[0][8]  = r_word(7'h00, 3'b110, 9, 8, 5);
        programs[0][9]  = r_word(7'h00, 3'b000, 10, 9, 7);
        programs[0][10] = s_word(10, 0, RESULT_ADDR);
        programs[0][11] = j_word(0, 0);
        // store, reload and use at once to get 40 + 40 + 3
        programs[1][0]  = i_word(OPC_IMM, 3'b000, 1, 0, 40);
        programs[1][1]  = s_word(1, 0, 64);
        programs[1][2]  = i_word(OPC_LOAD, 3'b010, 2, 0, 64);
        programs[1][3]  = r_word(7'h00, 3'b000, 3, 2, 1);
        programs[1][4]  = i_word(OPC_IMM, 3'b000, 4, 3, 3);
        programs[1][5]  = s_word(4, 0, RESULT_ADDR);
        programs[1][6]  = j_word(0, 0);
        // the adds right after a taken branch must be flushed
        programs[2][0]  = i_word(OPC_IMM, 3'b000, 1, 0, 3);
        programs[2][1]  = i_word(OPC_IMM, 3'b000, 2, 0, -2);
        programs[2][2]  = b_word(3'b000, 1, 2, 8);
        programs[2][3]  = b_word(3'b100, 2, 1, 8);
        programs[2][4]  = i_word(OPC_IMM, 3'b000, 1, 1, 100);
        programs[2][5]  = b_word(3'b001, 1, 2, 8);
        programs[2][6]  = i_word(OPC_IMM, 3'b000, 1, 1, 100);
        programs[2][7]  = b_word(3'b101, 2, 1, 8);
        programs[2][8]  = i_word(OPC_IMM, 3'b000, 1, 1, 10);
        programs[2][9]  = b_word(3'b001, 1, 1, 8);
        programs[2][10] = s_word(1, 0, RESULT_ADDR);
        programs[2][11] = j_word(0, 0);
        // jal links 4, jalr to (4 + 33) with bit 0 cleared links 32
        programs[3][0]  = j_word(5, 12);
        programs[3][1]  = i_word(OPC_IMM, 3'b000, 5, 5, 100);
        programs[3][2]  = i_word(OPC_IMM, 3'b000, 5, 5, 100);
        programs[3][3]  = b_word(3'b000, 5, 5, 8);
        programs[3][4]  = i_word(OPC_IMM, 3'b000, 5, 5, 50);
        programs[3][5]  = b_word(3'b101, 5, 0, 8);
        programs[3][6]  = i_word(OPC_IMM, 3'b000, 5, 5, 50);
        programs[3][7]  = i_word(OPC_JALR, 3'b000, 6, 5, 33);
        programs[3][8]  = i_word(OPC_IMM, 3'b000, 6, 6, 1);
        programs[3][9]  = r_word(7'h00, 3'b000, 7, 5, 6);
        programs[3][10] = s_word(7, 0, RESULT_ADDR);
        programs[3][11] = j_word(0, 0);
        // (0x12345000 + 0x1004) ^ 0xfffff000
        programs[4][0]  = u_word(OPC_LUI, 1, 20'h12345);
        programs[4][1]  = u_word(OPC_AUIPC, 2, 20'h00001);
        programs[4][2]  = b_word(3'b100, 1, 2, 8);
        programs[4][3]  = r_word(7'h00, 3'b000, 3, 1, 2);
        programs[4][4]  = u_word(OPC_LUI, 4, 20'hfffff);
        programs[4][5]  = r_word(7'h00, 3'b100, 5, 3, 4);
        programs[4][6]  = s_word(5, 0, RESULT_ADDR);
        programs[4][7]  = j_word(0, 0);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_program(input int p);
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < PROG_WORDS) ? programs[p][i] : NOP_WORD;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hc0de_0000 ^ (i << 2);
        end
    endtask

    task automatic reset_dut(input int p);
        @(posedge clk);
        arst_n     <= 1'b0;
        stall_pipl <= 1'b0;
        @(negedge clk);
        load_program(p);
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("reset_pc", RESET_PC_EXP, current_pc);
        assert (!mem_write_mem && !mem_read_mem) else begin
            $display("memory strobes are active right after reset");
            $display("=== FAIL ===");
            $fatal(1, "bus not idle after reset");
        end
    endtask

    task automatic run_test(input int t);
        bit found;
        found = 1'b0;
        while (!found) begin
            @(posedge clk);
            stall_pipl <= test_stall[t] ? 1'($urandom % 2) : 1'b0;
            @(negedge clk);
            assert (!(stall_pipl && if_id_reg_en)) else begin
                $display("if_id_reg_en is high while stall_pipl is high in %s", test_name[t]);
                $display("=== FAIL ===");
                $fatal(1, "stall not honored");
            end
            if (mem_write_mem || mem_read_mem) begin
                check_value({test_name[t], "_mem_op"}, {29'b0, F3_WORD}, {29'b0, mem_op_mem});
            end
            found = mem_write_mem && (mem_addr_mem == RESULT_ADDR);
        end
        // let the store land, then read the word back
        @(posedge clk);
        @(negedge clk);
        check_value(test_name[t], test_exp[t], dmem[RESULT_WORD]);
    endtask

    initial begin
        arst_n     = 1'b0;
        stall_pipl = 1'b0;
        void'($urandom(SEED));
        build_programs();
        for (int t = 0; t < NUM_TESTS; t++) begin
            reset_dut(test_prog[t]);
            run_test(t);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- vlog.f
common/rv32i_isa_pkg.sv
common/rv32i_pipe_pkg.sv
data_path/alu.sv
data_path/reg_file.sv
data_path/data_path.sv
control_unit/control_unit.sv
source/rv32i.sv
verif/rv32i_tb.sv
